// File: sources.f
common/icache_pkg.sv
icache/icache_controller.sv
icache/icache_datapath.sv
rtl/icache_top.sv
testbench/icache_assertions.sv
testbench/tb_icache.sv

// File: Makefile
# Verilator build for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= SIMULATION PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	status=$$?; \
	printf '%s\n' "$$out"; \
	[ $$status -eq 0 ] || exit 1; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/tb_icache.sv
// Directed testbench for the instruction cache with an instruction memory model
// Memory words are the inverse of their byte address and refills take 1 to 8 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

  localparam int unsigned TIMEOUT   = 50;
  localparam int unsigned QUIET_CYC = 20;
  localparam logic [31:0] LFSR_SEED = 32'h130c_6634;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic flush;
  logic imem_sel;
  logic fetch_req;
  logic fetch_kill;
  icache_pkg::icache_addr_t fetch_addr;
  logic fetch_ack;
  icache_pkg::icache_word_t fetch_instr;
  logic mem_req;
  icache_pkg::icache_addr_t mem_addr;
  logic mem_ack = 1'b0;
  icache_pkg::icache_line_t mem_line = '0;

  logic [31:0] lfsr_state;
  int error_count = 0;
  int check_count = 0;
  // Lines that memory delivered and the cache accepted
  int refill_count = 0;

  icache_top dut_i (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .icache_flush_i       (flush),
    .imem_sel_i           (imem_sel),
    .if2icache_req_i      (fetch_req),
    .if2icache_req_kill_i (fetch_kill),
    .if2icache_addr_i     (fetch_addr),
    .icache2if_ack_o      (fetch_ack),
    .icache2if_instr_o    (fetch_instr),
    .mem2icache_ack_i     (mem_ack),
    .mem2icache_line_i    (mem_line),
    .icache2mem_req_o     (mem_req),
    .icache2mem_addr_o    (mem_addr)
  );

  bind icache_controller icache_assertions assertions_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .imem_sel_i  (imem_sel_i),
    .req_kill_i  (if2icache_req_kill_i),
    .mem_ack_i   (mem2icache_ack_i),
    .mem_req_i   (icache2mem_req_o),
    .cache_rw_i  (cache_rw_o),
    .fetch_ack_i (icache2if_ack_o),
    .state_i     (state_q)
  );

  always #5 clk_i = ~clk_i;

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Word aligned random fetch address
  function automatic icache_pkg::icache_addr_t rand_addr();
    logic [31:0] r;
    r = rand_bits(30);
    return {r[29:0], 2'b00};
  endfunction

  // Every memory word is the inverse of its byte address
  function automatic icache_pkg::icache_line_t build_line(input icache_pkg::icache_addr_t a);
    icache_pkg::icache_line_t line;
    for (int unsigned w = 0; w < icache_pkg::ICACHE_WORDS_PER_LINE; w++) begin
      line[w*32 +: 32] = ~(a + 32'(4 * w));
    end
    return line;
  endfunction

  task automatic check_value(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Error [%s] %s: expected %h, actual %h", test, what, expected, actual);
    end
  endtask

  task automatic report_timeout(input string test, input string what);
    error_count++;
    $display("Timeout in %s: no %s within %0d cycles", test, what, TIMEOUT);
  endtask

  // Memory model that drops the request silently when the cache lets go of it
  always begin : memory_model
    int unsigned delay;
    logic dropped;
    icache_pkg::icache_addr_t line_addr;
    @(negedge clk_i);
    if (mem_req) begin
      delay = 32'd1 + rand_bits(3);
      line_addr = mem_addr;
      dropped = 1'b0;
      for (int unsigned i = 1; (i < delay) && !dropped; i++) begin
        @(negedge clk_i);
        dropped = ~mem_req;
      end
      if (!dropped) begin
        @(posedge clk_i);
        #1;
        mem_ack = 1'b1;
        mem_line = build_line(line_addr);
        @(negedge clk_i);
        // A kill in the ack cycle means the line is thrown away
        if (!fetch_kill && imem_sel) begin
          refill_count++;
        end
        @(posedge clk_i);
        #1;
        mem_ack = 1'b0;
      end
    end
  end

  // Holds the request until the ack, then lets the trailing ack drain
  task automatic fetch_word(input string test, input icache_pkg::icache_addr_t addr,
                            output icache_pkg::icache_word_t word);
    int unsigned waited;
    logic seen;
    waited = 0;
    seen = 1'b0;
    word = '0;
    @(posedge clk_i);
    #1;
    fetch_req = 1'b1;
    fetch_addr = addr;
    while (!seen && waited < TIMEOUT) begin
      @(negedge clk_i);
      seen = fetch_ack;
      word = fetch_instr;
      waited++;
    end
    if (!seen) begin
      report_timeout(test, "fetch acknowledge");
    end
    @(posedge clk_i);
    #1;
    fetch_req = 1'b0;
    @(posedge clk_i);
  endtask

  task automatic cold_miss_then_hit(output icache_pkg::icache_addr_t addr);
    icache_pkg::icache_word_t word;
    int start;
    addr = rand_addr();
    start = refill_count;
    fetch_word("cold_miss", addr, word);
    check_value("cold_miss", "word", ~addr, word);
    check_value("cold_miss", "refills", start + 1, refill_count);
    // Other word of the same line hits
    fetch_word("cold_miss", addr ^ 32'h4, word);
    check_value("cold_miss", "second word", ~(addr ^ 32'h4), word);
    check_value("cold_miss", "refills after hit", start + 1, refill_count);
  endtask

  task automatic stream_hits();
    icache_pkg::icache_addr_t base;
    icache_pkg::icache_word_t word;
    base = rand_addr() & 32'hffff_fff0;
    fetch_word("streaming", base, word);
    @(posedge clk_i);
    #1;
    fetch_req = 1'b1;
    fetch_addr = base;
    // New address every cycle with the ack one cycle behind each request
    for (int k = 0; k < 4; k++) begin
      @(posedge clk_i);
      #1;
      if (k < 3) begin
        fetch_addr = base + 32'(4 * (k + 1));
      end else begin
        fetch_req = 1'b0;
      end
      @(negedge clk_i);
      check_value("streaming", "ack", 32'd1, 32'(fetch_ack));
      check_value("streaming", "word", ~(base + 32'(4 * k)), fetch_instr);
    end
    @(negedge clk_i);
    check_value("streaming", "ack after stream", 32'd0, 32'(fetch_ack));
  endtask

  task automatic evict_on_conflict();
    icache_pkg::icache_addr_t a1;
    icache_pkg::icache_addr_t a2;
    icache_pkg::icache_word_t word;
    int start;
    a1 = rand_addr();
    // Same index with a different top tag bit
    a2 = a1 ^ 32'h8000_0000;
    start = refill_count;
    fetch_word("conflict", a1, word);
    check_value("conflict", "first word", ~a1, word);
    fetch_word("conflict", a2, word);
    check_value("conflict", "second word", ~a2, word);
    fetch_word("conflict", a1, word);
    check_value("conflict", "first word again", ~a1, word);
    check_value("conflict", "refills", start + 3, refill_count);
  endtask

  task automatic kill_refill();
    icache_pkg::icache_addr_t addr;
    icache_pkg::icache_word_t word;
    int start;
    int unsigned waited;
    logic seen;
    addr = rand_addr();
    start = refill_count;
    waited = 0;
    seen = 1'b0;
    @(posedge clk_i);
    #1;
    fetch_req = 1'b1;
    fetch_addr = addr;
    while (!seen && waited < TIMEOUT) begin
      @(negedge clk_i);
      seen = mem_req;
      waited++;
    end
    if (!seen) begin
      report_timeout("kill", "memory request");
    end
    // Refill asks for word 0 of the line
    check_value("kill", "memory address", addr & 32'hffff_fff0, mem_addr);
    // Kill the open refill and keep the request up under the kill
    @(posedge clk_i);
    #1;
    fetch_kill = 1'b1;
    for (int i = 0; i < 4; i++) begin
      @(negedge clk_i);
      check_value("kill", "memory request under kill", 32'd0, 32'(mem_req));
      check_value("kill", "ack under kill", 32'd0, 32'(fetch_ack));
    end
    @(posedge clk_i);
    #1;
    fetch_kill = 1'b0;
    fetch_req = 1'b0;
    check_value("kill", "refills after kill", start, refill_count);
    fetch_word("kill", addr, word);
    check_value("kill", "word", ~addr, word);
    check_value("kill", "refills", start + 1, refill_count);
    // Kill on a cached line suppresses the ack of the next cycle
    @(posedge clk_i);
    #1;
    fetch_req = 1'b1;
    fetch_kill = 1'b1;
    fetch_addr = addr;
    @(posedge clk_i);
    #1;
    fetch_req = 1'b0;
    fetch_kill = 1'b0;
    @(negedge clk_i);
    check_value("kill", "ack after killed hit", 32'd0, 32'(fetch_ack));
  endtask

  task automatic deselect_cache(input icache_pkg::icache_addr_t cached_addr);
    icache_pkg::icache_word_t word;
    int unsigned waited;
    int unsigned acks;
    int unsigned reqs;
    waited = 0;
    acks = 0;
    reqs = 0;
    // Line must be present so that the deselected fetch would hit
    fetch_word("deselect", cached_addr, word);
    check_value("deselect", "word before deselect", ~cached_addr, word);
    // Cached address first, then one that would miss
    while (waited < QUIET_CYC) begin
      @(posedge clk_i);
      #1;
      imem_sel = 1'b0;
      fetch_req = 1'b1;
      fetch_addr = (waited < QUIET_CYC / 2) ? cached_addr : (cached_addr ^ 32'h8000_0000);
      @(negedge clk_i);
      acks += 32'(fetch_ack);
      reqs += 32'(mem_req);
      waited++;
    end
    @(posedge clk_i);
    #1;
    fetch_req = 1'b0;
    imem_sel = 1'b1;
    check_value("deselect", "fetch acks", 32'd0, acks);
    check_value("deselect", "memory requests", 32'd0, reqs);
  endtask

  task automatic flush_and_refill();
    icache_pkg::icache_addr_t f1;
    icache_pkg::icache_addr_t f2;
    icache_pkg::icache_word_t word;
    int start;
    f1 = rand_addr();
    f2 = f1 + 32'h10;
    fetch_word("flush", f1, word);
    fetch_word("flush", f2, word);
    @(posedge clk_i);
    #1;
    flush = 1'b1;
    @(posedge clk_i);
    #1;
    flush = 1'b0;
    start = refill_count;
    fetch_word("flush", f1, word);
    check_value("flush", "first word", ~f1, word);
    fetch_word("flush", f2, word);
    check_value("flush", "second word", ~f2, word);
    check_value("flush", "refills", start + 2, refill_count);
  endtask

  initial begin : main
    icache_pkg::icache_addr_t cached_addr;
    rst_ni = 1'b0;
    flush = 1'b0;
    imem_sel = 1'b1;
    fetch_req = 1'b0;
    fetch_kill = 1'b0;
    fetch_addr = '0;
    lfsr_state = LFSR_SEED;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("reset", "fetch ack", 32'd0, 32'(fetch_ack));
    check_value("reset", "memory request", 32'd0, 32'(mem_req));
    cold_miss_then_hit(cached_addr);
    stream_hits();
    evict_on_conflict();
    kill_refill();
    deselect_cache(cached_addr);
    flush_and_refill();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/icache_assertions.sv
// Protocol checks on the cache controller, bound in from the testbench
// All checks are off while reset is low
`timescale 1ns/1ps
`default_nettype none

module icache_assertions (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      imem_sel_i,
  input logic                      req_kill_i,
  input logic                      mem_ack_i,
  input logic                      mem_req_i,
  input logic                      cache_rw_i,
  input logic                      fetch_ack_i,
  input icache_pkg::icache_state_e state_i
);

  // Open refill keeps its request until memory answers or fetch aborts
  req_held_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_i && !mem_ack_i) |=> (mem_req_i || mem_ack_i || req_kill_i || !imem_sel_i))
    else $error("memory request dropped while the refill was still open");

  // Line write only with the memory ack
  write_needs_ack_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cache_rw_i |-> mem_ack_i)
    else $error("line written without a memory acknowledge");

  // Deselect suppresses the next fetch ack
  no_ack_deselected_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !imem_sel_i |=> !fetch_ack_i)
    else $error("fetch acknowledge after a deselected cycle");

  // READ_MEMORY is only legal after a cycle with an open refill request
  legal_state_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == icache_pkg::ICACHE_READ_MEMORY) |-> $past(mem_req_i))
    else $error("controller waits for memory without an open refill");

endmodule

`default_nettype wire

// File: rtl/icache_top.sv
// Instruction cache top level, controller plus storage datapath
// Flush is only allowed while no refill is open
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Invalidate the whole cache
  input  logic                     icache_flush_i,
  // Low while fetch runs from boot memory
  input  logic                     imem_sel_i,

  // Fetch side
  input  logic                     if2icache_req_i,
  input  logic                     if2icache_req_kill_i,
  input  icache_pkg::icache_addr_t if2icache_addr_i,
  output logic                     icache2if_ack_o,
  output icache_pkg::icache_word_t icache2if_instr_o,

  // Instruction memory side
  input  logic                     mem2icache_ack_i,
  input  icache_pkg::icache_line_t mem2icache_line_i,
  output logic                     icache2mem_req_o,
  output icache_pkg::icache_addr_t icache2mem_addr_o
);

  // Tag compare result, datapath to controller
  logic cache_hit;
  // Line write strobe, controller to datapath
  logic cache_rw;

  icache_controller controller_i (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .cache_hit_i          (cache_hit),
    .cache_rw_o           (cache_rw),
    .imem_sel_i           (imem_sel_i),
    .if2icache_req_i      (if2icache_req_i),
    .if2icache_req_kill_i (if2icache_req_kill_i),
    .icache2if_ack_o      (icache2if_ack_o),
    .mem2icache_ack_i     (mem2icache_ack_i),
    .icache2mem_req_o     (icache2mem_req_o)
  );

  icache_datapath datapath_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .icache_flush_i    (icache_flush_i),
    .if2icache_addr_i  (if2icache_addr_i),
    .cache_rw_i        (cache_rw),
    .mem2icache_line_i (mem2icache_line_i),
    .cache_hit_o       (cache_hit),
    .icache2if_instr_o (icache2if_instr_o),
    .icache2mem_addr_o (icache2mem_addr_o)
  );

endmodule

`default_nettype wire

// File: icache/icache_datapath.sv
// Tag, valid and data storage of the direct-mapped instruction cache
// Low address bits are ignored, fetches are assumed word aligned
`timescale 1ns/1ps
`default_nettype none

module icache_datapath (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Clears every valid bit at the next edge
  input  logic                     icache_flush_i,

  // Fetch address, held by fetch until acked or killed
  input  icache_pkg::icache_addr_t if2icache_addr_i,

  // Line fill from memory
  input  logic                     cache_rw_i,
  input  icache_pkg::icache_line_t mem2icache_line_i,

  // Tag compare result for the current address
  output logic                     cache_hit_o,
  // Registered word, lines up with the controller ack
  output icache_pkg::icache_word_t icache2if_instr_o,
  // Line-aligned refill address
  output icache_pkg::icache_addr_t icache2mem_addr_o
);

  localparam int unsigned NUM_SETS = icache_pkg::ICACHE_NUM_SETS;
  localparam int unsigned WORD_W   = icache_pkg::ICACHE_WORD_W;
  localparam int unsigned TAG_LSB  = icache_pkg::ICACHE_ADDR_W - icache_pkg::ICACHE_TAG_W;
  localparam int unsigned IDX_LSB  = icache_pkg::ICACHE_OFFSET_W
                                     + icache_pkg::ICACHE_BYTE_OFF_W;
  localparam int unsigned OFF_LSB  = icache_pkg::ICACHE_BYTE_OFF_W;

  // Storage arrays
  icache_pkg::icache_tag_t  tag_q  [NUM_SETS];
  icache_pkg::icache_line_t data_q [NUM_SETS];
  logic [NUM_SETS-1:0]      valid_q;

  // Address fields of the current fetch
  icache_pkg::icache_tag_t    addr_tag;
  icache_pkg::icache_index_t  addr_index;
  icache_pkg::icache_offset_t addr_offset;

  // Contents of the indexed set
  icache_pkg::icache_tag_t  rd_tag;
  icache_pkg::icache_line_t rd_line;
  logic                     rd_valid;

  // Word picked out of the indexed line
  icache_pkg::icache_word_t word_sel;

  // Output word register
  icache_pkg::icache_word_t instr_q;

  // Split the byte address, bits below OFF_LSB are dropped
  assign addr_tag    = if2icache_addr_i[icache_pkg::ICACHE_ADDR_W-1:TAG_LSB];
  assign addr_index  = if2icache_addr_i[TAG_LSB-1:IDX_LSB];
  assign addr_offset = if2icache_addr_i[IDX_LSB-1:OFF_LSB];

  // Read the indexed set
  assign rd_tag   = tag_q[addr_index];
  assign rd_line  = data_q[addr_index];
  assign rd_valid = valid_q[addr_index];

  // Hit needs both the valid bit and a matching tag
  assign cache_hit_o = rd_valid & (rd_tag == addr_tag);

  // Word 0 in the low bits of the line
  assign word_sel = rd_line[addr_offset * WORD_W +: WORD_W];

  // Refill starts at word 0 of the line
  assign icache2mem_addr_o = {addr_tag, addr_index, {IDX_LSB{1'b0}}};

  // Valid bits, cleared on reset and on flush
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (icache_flush_i) begin
      valid_q <= '0;
    end else if (cache_rw_i) begin
      valid_q[addr_index] <= 1'b1;
    end
  end

  // Tag and data arrays, written only by a line fill
  always_ff @(posedge clk_i) begin
    if (cache_rw_i) begin
      tag_q[addr_index]  <= addr_tag;
      data_q[addr_index] <= mem2icache_line_i;
    end
  end

  // Word register loads every cycle
  // Only meaningful when the controller raises its ack next cycle
  always_ff @(posedge clk_i) begin
    instr_q <= word_sel;
  end

  assign icache2if_instr_o = instr_q;

endmodule

`default_nettype wire

// File: icache/icache_controller.sv
// Hit/miss FSM of the instruction cache
// Kill or deselect aborts a refill at once; the memory ack is ignored in IDLE
`timescale 1ns/1ps
`default_nettype none

module icache_controller (
  input  logic clk_i,
  input  logic rst_ni,

  // From datapath tag compare
  input  logic cache_hit_i,
  // Line write strobe to datapath
  output logic cache_rw_o,

  // Low while fetch runs from boot memory
  input  logic imem_sel_i,

  // Fetch side
  input  logic if2icache_req_i,
  input  logic if2icache_req_kill_i,
  output logic icache2if_ack_o,

  // Instruction memory side
  input  logic mem2icache_ack_i,
  output logic icache2mem_req_o
);

  icache_pkg::icache_state_e state_q;
  icache_pkg::icache_state_e state_d;

  // Request that is allowed to touch the cache this cycle
  logic fetch_valid;
  logic fetch_hit;
  logic fetch_miss;
  // Kill or deselect, overrides everything
  logic abort;

  assign abort       = if2icache_req_kill_i | ~imem_sel_i;
  assign fetch_valid = if2icache_req_i & ~abort;
  assign fetch_hit   = fetch_valid & cache_hit_i;
  assign fetch_miss  = fetch_valid & ~cache_hit_i;

  // State register
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= icache_pkg::ICACHE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Next state and memory side strobes
  always_comb begin
    state_d          = state_q;
    icache2mem_req_o = 1'b0;
    cache_rw_o       = 1'b0;

    unique case (state_q)
      icache_pkg::ICACHE_IDLE: begin
        // Miss opens the refill in the same cycle
        if (fetch_miss) begin
          icache2mem_req_o = 1'b1;
          state_d          = icache_pkg::ICACHE_READ_MEMORY;
        end
      end

      icache_pkg::ICACHE_READ_MEMORY: begin
        if (mem2icache_ack_i) begin
          // Line arrives with the ack, write it at this edge
          cache_rw_o = 1'b1;
          state_d    = icache_pkg::ICACHE_IDLE;
        end else begin
          // Hold the request until memory answers
          icache2mem_req_o = 1'b1;
        end
      end

      default: begin
        state_d = icache_pkg::ICACHE_IDLE;
      end
    endcase

    // Jump, branch, trap or interrupt, or a switch to boot memory
    // Drop the refill and write nothing
    if (abort) begin
      state_d          = icache_pkg::ICACHE_IDLE;
      icache2mem_req_o = 1'b0;
      cache_rw_o       = 1'b0;
    end
  end

  // Ack leaves together with the registered word from the datapath
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      icache2if_ack_o <= 1'b0;
    end else begin
      icache2if_ack_o <= fetch_hit;
    end
  end

endmodule

`default_nettype wire

// File: common/icache_pkg.sv
// Geometry, field types and controller states shared by the instruction cache
// Direct-mapped, line size and set count must stay powers of two
`default_nettype none

package icache_pkg;

  // Cache geometry
  localparam int unsigned ICACHE_NUM_SETS       = 16;
  localparam int unsigned ICACHE_WORDS_PER_LINE = 4;

  // Fetch address and instruction word widths
  localparam int unsigned ICACHE_ADDR_W = 32;
  localparam int unsigned ICACHE_WORD_W = 32;

  // Byte bits below the word offset, always zero for aligned fetches
  localparam int unsigned ICACHE_BYTE_OFF_W = 2;

  // Word offset inside a line
  localparam int unsigned ICACHE_OFFSET_W = $clog2(ICACHE_WORDS_PER_LINE);

  // Set index
  localparam int unsigned ICACHE_INDEX_W = $clog2(ICACHE_NUM_SETS);

  // Tag takes everything above index, word offset and byte bits
  localparam int unsigned ICACHE_TAG_W =
    ICACHE_ADDR_W - ICACHE_INDEX_W - ICACHE_OFFSET_W - ICACHE_BYTE_OFF_W;

  // Full line as delivered by instruction memory
  localparam int unsigned ICACHE_LINE_W = ICACHE_WORD_W * ICACHE_WORDS_PER_LINE;

  // Byte address from fetch, also used for the line address to memory
  typedef logic [ICACHE_ADDR_W-1:0] icache_addr_t;

  // One instruction word
  typedef logic [ICACHE_WORD_W-1:0] icache_word_t;

  // One line, word 0 sits in the low bits
  typedef logic [ICACHE_LINE_W-1:0] icache_line_t;

  // Address fields
  typedef logic [ICACHE_TAG_W-1:0]    icache_tag_t;
  typedef logic [ICACHE_INDEX_W-1:0]  icache_index_t;
  typedef logic [ICACHE_OFFSET_W-1:0] icache_offset_t;

  // Controller states
  // IDLE serves hits, READ_MEMORY waits for a line refill
  typedef enum logic [0:0] {
    ICACHE_IDLE        = 1'b0,
    ICACHE_READ_MEMORY = 1'b1
  } icache_state_e;

endpackage

`default_nettype wire
